// ==== files.f ====
+incdir+.
rvPkg.sv
rvDecoder.sv
rvAlu.sv
rvHazardUnit.sv
riscvTop.sv
tbRvModels.sv
tbRiscvTop.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rvPkg.sv
      - rvDecoder.sv
      - rvAlu.sv
      - rvHazardUnit.sv
      - riscvTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbRvModels.sv
      - tbRiscvTop.sv

// ==== tbRiscvTop.sv ====
`default_nettype none
`include "rvCore_consts.svh"

module tbRiscvTop;

   // six programs, at most 40 instructions, 5 cycles each, plus reset and drain margin
   localparam int NUM_PROGS      = 6;
   localparam int MAX_INSTR      = 40;
   localparam int TIMEOUT_CYCLES = NUM_PROGS * MAX_INSTR * 5 + 800;
   localparam logic [31:0] EBREAK = 32'h0010_0073;

   logic                CLK;
   logic                RSTn;
   logic                I_MEM_CSN;
   logic [`IADDR_W-1:0] I_MEM_ADDR;
   logic [`XLEN-1:0]    I_MEM_DI;
   logic                D_MEM_CSN;
   logic                D_MEM_WEN;
   logic [`DADDR_W-1:0] D_MEM_ADDR;
   logic [`XLEN-1:0]    D_MEM_DOUT;
   logic [`XLEN-1:0]    D_MEM_DI;
   logic                RF_WE;
   logic [4:0]          RF_RA1;
   logic [4:0]          RF_RA2;
   logic [4:0]          RF_WA1;
   logic [`XLEN-1:0]    RF_RD1;
   logic [`XLEN-1:0]    RF_RD2;
   logic [`XLEN-1:0]    RF_WD;
   logic                HALT;
   logic [`XLEN-1:0]    NUM_INST;
   logic [`XLEN-1:0]    OUTPUT_PORT;

   // program under construction and its expected register writes
   logic [31:0] prog [$];
   logic [4:0]  expRd [$];
   logic [31:0] expWd [$];
   logic [4:0]  gotRd [$];
   logic [31:0] gotWd [$];
   logic [31:0] shadow [0:31];
   logic [31:0] lfsr;
   logic        collecting;
   int          execCount;
   int          cycleCount;
   int          errorCount;

   riscvTop i_riscvTop (
      .CLK(CLK), .RSTn(RSTn), .I_MEM_CSN(I_MEM_CSN), .I_MEM_ADDR(I_MEM_ADDR),
      .I_MEM_DI(I_MEM_DI), .D_MEM_CSN(D_MEM_CSN), .D_MEM_WEN(D_MEM_WEN),
      .D_MEM_ADDR(D_MEM_ADDR), .D_MEM_DOUT(D_MEM_DOUT), .D_MEM_DI(D_MEM_DI),
      .RF_WE(RF_WE), .RF_RA1(RF_RA1), .RF_RA2(RF_RA2), .RF_WA1(RF_WA1),
      .RF_RD1(RF_RD1), .RF_RD2(RF_RD2), .RF_WD(RF_WD), .HALT(HALT),
      .NUM_INST(NUM_INST), .OUTPUT_PORT(OUTPUT_PORT)
   );

   tbRvModels models (
      .CLK(CLK), .I_MEM_CSN(I_MEM_CSN), .I_MEM_ADDR(I_MEM_ADDR), .I_MEM_DI(I_MEM_DI),
      .D_MEM_CSN(D_MEM_CSN), .D_MEM_WEN(D_MEM_WEN), .D_MEM_ADDR(D_MEM_ADDR),
      .D_MEM_DOUT(D_MEM_DOUT), .D_MEM_DI(D_MEM_DI), .RF_WE(RF_WE), .RF_RA1(RF_RA1),
      .RF_RA2(RF_RA2), .RF_WA1(RF_WA1), .RF_WD(RF_WD), .RF_RD1(RF_RD1), .RF_RD2(RF_RD2)
   );

   always #10 CLK = ~CLK;

   // writeback monitor, sampled mid-cycle
   always @(negedge CLK) begin
      if (collecting && RF_WE) begin
         gotRd.push_back(RF_WA1);
         gotWd.push_back(OUTPUT_PORT);
      end
   end

   task automatic stopOnFailure();
      errorCount++;
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic failValue(input string sig, input logic [31:0] got, input logic [31:0] exp);
      $display("Error at %0t: %s is %h, expected %h", $time, sig, got, exp);
      stopOnFailure();
   endtask

   task automatic failText(input string msg);
      $display("Error at %0t: %s", $time, msg);
      stopOnFailure();
   endtask

   always @(posedge CLK) begin
      cycleCount++;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         failText("the core never halted, cycle limit reached");
      end
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic randomBits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrNext(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // rv32i arithmetic, slt is signed
   function automatic logic [31:0] aluRule(input string op, input logic [31:0] a, b);
      if (op == "sub") return a - b;
      if (op == "and") return a & b;
      if (op == "or") return a | b;
      if (op == "xor") return a ^ b;
      if (op == "slt") return {31'd0, $signed(a) < $signed(b)};
      return a + b;
   endfunction

   function automatic logic [2:0] funct3Of(input string op);
      if (op == "slt") return 3'b010;
      if (op == "xor") return 3'b100;
      if (op == "or") return 3'b110;
      if (op == "and") return 3'b111;
      return 3'b000;
   endfunction

   task automatic newProgram();
      prog.delete();
      expRd.delete();
      expWd.delete();
      execCount = 0;
      for (int i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
   endtask

   task automatic emit(input logic [31:0] word, input bit executed);
      prog.push_back(word);
      if (executed) begin
         execCount++;
      end
   endtask

   task automatic expectWrite(input logic [4:0] rd, input logic [31:0] val);
      expRd.push_back(rd);
      expWd.push_back(val);
      if (rd != 5'd0) begin
         shadow[rd] = val;
      end
   endtask

   task automatic rOp(input string op, input logic [4:0] rd, rs1, rs2);
      logic [6:0] f7;
      f7 = (op == "sub") ? 7'b0100000 : 7'b0000000;
      emit({f7, rs2, rs1, funct3Of(op), rd, `OPC_OP}, 1'b1);
      expectWrite(rd, aluRule(op, shadow[rs1], shadow[rs2]));
   endtask

   task automatic iOp(input string op, input logic [4:0] rd, rs1, input logic [11:0] imm);
      emit({imm, rs1, funct3Of(op), rd, `OPC_OP_IMM}, 1'b1);
      expectWrite(rd, aluRule(op, shadow[rs1], {{20{imm[11]}}, imm}));
   endtask

   task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
      emit({imm, rd, `OPC_LUI}, 1'b1);
      expectWrite(rd, {imm, 12'd0});
   endtask

   // fetched behind a redirect or ebreak, must never retire
   task automatic skipped(input logic [4:0] rd);
      emit({12'h7ff, 5'd0, 3'b000, rd, `OPC_OP_IMM}, 1'b0);
   endtask

   // branch forward over the next two instructions
   task automatic branchOver2(input string cond, input logic [4:0] rs1, rs2);
      logic [12:0] off;
      logic [2:0]  f3;
      logic        lt;
      logic        taken;
      off   = 13'd12;
      lt    = $signed(shadow[rs1]) < $signed(shadow[rs2]);
      f3    = 3'b000;
      taken = shadow[rs1] == shadow[rs2];
      if (cond == "bne") begin
         f3    = 3'b001;
         taken = shadow[rs1] != shadow[rs2];
      end else if (cond == "blt") begin
         f3    = 3'b100;
         taken = lt;
      end else if (cond == "bge") begin
         f3    = 3'b101;
         taken = !lt;
      end
      emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH}, 1'b1);
      if (taken) begin
         skipped(5'd30);
         skipped(5'd31);
      end else begin
         iOp("add", 5'd30, 5'd0, 12'h0a5);
         iOp("add", 5'd31, 5'd0, 12'h05a);
      end
   endtask

   task automatic jalOver2(input logic [4:0] rd);
      logic [20:0] off;
      logic [31:0] pc;
      off = 21'd12;
      pc  = prog.size() * 4;
      emit({off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL}, 1'b1);
      expectWrite(rd, pc + 32'd4);
      skipped(5'd30);
      skipped(5'd31);
   endtask

   // base gets the target with bit 0 set, jalr must clear it
   task automatic jalrOver2(input logic [4:0] base, rd);
      logic [31:0] target;
      target = (prog.size() + 4) * 4;
      iOp("add", base, 5'd0, target[11:0] + 12'd1);
      emit({12'd0, base, 3'b000, rd, `OPC_JALR}, 1'b1);
      expectWrite(rd, prog.size() * 4);
      skipped(5'd30);
      skipped(5'd31);
   endtask

   // reset, load, run to HALT, then compare writes and retire count
   task automatic runProgram(input string name);
      int n;
      @(posedge CLK);
      RSTn <= 1'b1;
      collecting = 1'b0;
      repeat (2) @(posedge CLK);
      models.clearState();
      for (int i = 0; i < prog.size(); i++) begin
         models.imem[i] = prog[i];
      end
      gotRd.delete();
      gotWd.delete();
      repeat (6) @(posedge CLK);
      RSTn <= 1'b0;
      collecting = 1'b1;
      @(negedge CLK);
      while (!HALT) begin
         @(negedge CLK);
      end
      n = gotRd.size();
      repeat (10) @(negedge CLK);
      assert (gotRd.size() == n) else failText({name, ": register write after HALT"});
      assert (HALT) else failText({name, ": HALT dropped before reset"});
      assert (NUM_INST == execCount) else failValue("NUM_INST", NUM_INST, execCount);
      assert (gotRd.size() == expRd.size())
         else failValue("RF_WE pulse count", gotRd.size(), expRd.size());
      for (int i = 0; i < expRd.size(); i++) begin
         assert (gotRd[i] == expRd[i]) else failValue("RF_WA1", gotRd[i], expRd[i]);
         assert (gotWd[i] == expWd[i]) else failValue("OUTPUT_PORT", gotWd[i], expWd[i]);
      end
   endtask

   task automatic testAlu();
      logic [31:0] r;
      newProgram();
      randomBits(20, r);
      lui(5'd1, r[19:0]);
      randomBits(12, r);
      iOp("add", 5'd1, 5'd1, r[11:0]);
      randomBits(20, r);
      lui(5'd2, r[19:0]);
      randomBits(12, r);
      iOp("add", 5'd2, 5'd2, r[11:0]);
      rOp("add", 5'd3, 5'd1, 5'd2);
      rOp("sub", 5'd4, 5'd1, 5'd2);
      rOp("and", 5'd5, 5'd1, 5'd2);
      rOp("or", 5'd6, 5'd1, 5'd2);
      rOp("xor", 5'd7, 5'd1, 5'd2);
      rOp("slt", 5'd8, 5'd1, 5'd2);
      rOp("slt", 5'd9, 5'd2, 5'd1);
      randomBits(12, r);
      iOp("and", 5'd10, 5'd1, r[11:0]);
      randomBits(12, r);
      iOp("or", 5'd11, 5'd2, r[11:0]);
      randomBits(12, r);
      iOp("xor", 5'd12, 5'd1, r[11:0]);
      randomBits(12, r);
      iOp("slt", 5'd13, 5'd2, r[11:0]);
      emit(EBREAK, 1'b1);
      runProgram("alu");
   endtask

   // every instruction consumes the one just before it
   task automatic testForwarding();
      logic [31:0] r;
      newProgram();
      randomBits(12, r);
      iOp("add", 5'd1, 5'd0, r[11:0]);
      randomBits(12, r);
      iOp("add", 5'd2, 5'd0, r[11:0]);
      rOp("add", 5'd3, 5'd1, 5'd2);
      rOp("sub", 5'd4, 5'd3, 5'd1);
      rOp("add", 5'd5, 5'd4, 5'd3);
      rOp("sub", 5'd6, 5'd5, 5'd4);
      rOp("add", 5'd7, 5'd6, 5'd6);
      rOp("sub", 5'd1, 5'd7, 5'd5);
      rOp("add", 5'd1, 5'd1, 5'd7);
      rOp("add", 5'd1, 5'd1, 5'd1);
      emit(EBREAK, 1'b1);
      runProgram("forwarding");
   endtask

   task automatic testLoadUse();
      logic [31:0] r;
      logic [31:0] stored;
      logic [31:0] addr;
      newProgram();
      iOp("add", 5'd1, 5'd0, 12'h100);
      randomBits(20, r);
      lui(5'd2, r[19:0]);
      randomBits(12, r);
      iOp("add", 5'd2, 5'd2, r[11:0]);
      stored = shadow[2];
      addr   = shadow[1] + 32'd8;
      // sw x2, 8(x1) then lw x3, 8(x1)
      emit({7'd0, 5'd2, 5'd1, 3'b010, 5'd8, `OPC_STORE}, 1'b1);
      emit({12'd8, 5'd1, 3'b010, 5'd3, `OPC_LOAD}, 1'b1);
      expectWrite(5'd3, stored);
      randomBits(12, r);
      iOp("add", 5'd4, 5'd3, r[11:0]);
      emit(EBREAK, 1'b1);
      runProgram("load-use");
      assert (models.dmem[addr[`DADDR_W+1:2]] == stored)
         else failValue("data memory word", models.dmem[addr[`DADDR_W+1:2]], stored);
   endtask

   task automatic testControlFlow();
      newProgram();
      iOp("add", 5'd1, 5'd0, 12'd5);
      iOp("add", 5'd2, 5'd0, 12'd5);
      iOp("add", 5'd3, 5'd0, 12'hffd);
      branchOver2("beq", 5'd1, 5'd2);
      branchOver2("bne", 5'd1, 5'd3);
      // 5 < -3 is false when signed
      branchOver2("blt", 5'd1, 5'd3);
      branchOver2("bge", 5'd1, 5'd3);
      branchOver2("beq", 5'd1, 5'd3);
      emit(EBREAK, 1'b1);
      runProgram("branches");
      newProgram();
      jalOver2(5'd1);
      jalrOver2(5'd5, 5'd6);
      rOp("add", 5'd7, 5'd6, 5'd1);
      // return address here shows whether the jalr target kept bit 0
      jalOver2(5'd8);
      emit(EBREAK, 1'b1);
      runProgram("jumps");
   endtask

   task automatic testHaltCount();
      newProgram();
      iOp("add", 5'd1, 5'd0, 12'h123);
      rOp("add", 5'd2, 5'd1, 5'd1);
      emit(EBREAK, 1'b1);
      skipped(5'd3);
      skipped(5'd4);
      skipped(5'd5);
      runProgram("halt");
   endtask

   initial begin
      CLK        = 1'b0;
      RSTn       = 1'b1;
      collecting = 1'b0;
      cycleCount = 0;
      errorCount = 0;
      lfsr       = 32'h7fd9_db94;
      testAlu();
      testForwarding();
      testLoadUse();
      testControlFlow();
      testHaltCount();
      if (errorCount == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tbRvModels.sv ====
`default_nettype none
`include "rvCore_consts.svh"

module tbRvModels (
   input  logic                CLK,
   input  logic                I_MEM_CSN,
   input  logic [`IADDR_W-1:0] I_MEM_ADDR,
   output logic [`XLEN-1:0]    I_MEM_DI,
   input  logic                D_MEM_CSN,
   input  logic                D_MEM_WEN,
   input  logic [`DADDR_W-1:0] D_MEM_ADDR,
   input  logic [`XLEN-1:0]    D_MEM_DOUT,
   output logic [`XLEN-1:0]    D_MEM_DI,
   input  logic                RF_WE,
   input  logic [4:0]          RF_RA1,
   input  logic [4:0]          RF_RA2,
   input  logic [4:0]          RF_WA1,
   input  logic [`XLEN-1:0]    RF_WD,
   output logic [`XLEN-1:0]    RF_RD1,
   output logic [`XLEN-1:0]    RF_RD2
);

   // word arrays, imem indexed by the byte address without its low two bits
   logic [`XLEN-1:0] imem [0:(1<<(`IADDR_W-2))-1];
   logic [`XLEN-1:0] dmem [0:(1<<`DADDR_W)-1];
   logic [`XLEN-1:0] regs [0:31];

   // memories answer in the same cycle
   assign I_MEM_DI = I_MEM_CSN ? '0 : imem[I_MEM_ADDR[`IADDR_W-1:2]];
   assign D_MEM_DI = D_MEM_CSN ? '0 : dmem[D_MEM_ADDR];

   // x0 reads zero, a read of the register being written returns RF_WD
   assign RF_RD1 = (RF_RA1 == 5'd0) ? '0 :
                   (RF_WE && RF_WA1 == RF_RA1) ? RF_WD : regs[RF_RA1];
   assign RF_RD2 = (RF_RA2 == 5'd0) ? '0 :
                   (RF_WE && RF_WA1 == RF_RA2) ? RF_WD : regs[RF_RA2];

   always @(posedge CLK) begin
      if (RF_WE && RF_WA1 != 5'd0) begin
         regs[RF_WA1] <= RF_WD;
      end
      // D_MEM_WEN is active low
      if (!D_MEM_CSN && !D_MEM_WEN) begin
         dmem[D_MEM_ADDR] <= D_MEM_DOUT;
      end
   end

   // registers to zero, imem to nops, dmem to a per-address pattern
   task automatic clearState();
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < (1 << (`IADDR_W - 2)); i++) begin
         imem[i] = 32'h0000_0013;
      end
      for (int i = 0; i < (1 << `DADDR_W); i++) begin
         dmem[i] = {4'hd, i[11:0], 4'ha, i[11:0]};
      end
   endtask

endmodule

`default_nettype wire

// ==== riscvTop.sv ====
`default_nettype none
`include "rvCore_consts.svh"

module riscvTop (
   input  logic                CLK,
   input  logic                RSTn,
   output logic                I_MEM_CSN,
   output logic [`IADDR_W-1:0] I_MEM_ADDR,
   input  logic [`XLEN-1:0]    I_MEM_DI,
   output logic                D_MEM_CSN,
   output logic                D_MEM_WEN,
   output logic [`DADDR_W-1:0] D_MEM_ADDR,
   output logic [`XLEN-1:0]    D_MEM_DOUT,
   input  logic [`XLEN-1:0]    D_MEM_DI,
   output logic                RF_WE,
   output logic [4:0]          RF_RA1,
   output logic [4:0]          RF_RA2,
   output logic [4:0]          RF_WA1,
   input  logic [`XLEN-1:0]    RF_RD1,
   input  logic [`XLEN-1:0]    RF_RD2,
   output logic [`XLEN-1:0]    RF_WD,
   output logic                HALT,
   output logic [`XLEN-1:0]    NUM_INST,
   output logic [`XLEN-1:0]    OUTPUT_PORT
);
   import rvPkg::*;

   // fetch and IF/ID
   logic [`XLEN-1:0] pc;
   logic             ifIdValid;
   logic [`XLEN-1:0] ifIdInstr, ifIdPc;
   // decode results
   logic [4:0]       decRs1, decRs2, decRd;
   logic [`XLEN-1:0] decImm;
   aluOp_t           decAluOp;
   brCond_t          decBrCond;
   wbSel_t           decWbSel;
   logic             decAluSrcImm, decAluSrcPc, decRegWrite, decMemRead, decMemWrite;
   logic             decIsJump, decIsJalr, decIsHalt;
   // ID/EX
   logic             idExValid;
   logic [`XLEN-1:0] idExPc, idExRd1, idExRd2, idExImm;
   logic [4:0]       idExRs1, idExRs2, idExRd;
   aluOp_t           idExAluOp;
   brCond_t          idExBrCond;
   wbSel_t           idExWbSel;
   logic             idExAluSrcImm, idExAluSrcPc, idExRegWrite, idExMemRead, idExMemWrite;
   logic             idExIsJump, idExIsJalr, idExIsHalt;
   // execute
   fwdSel_t          fwdA, fwdB;
   logic [`XLEN-1:0] fwdRs1, fwdRs2, aluA, aluB, aluResult, exPc4, exTarget;
   logic             brTaken, redirect, stall, flush;
   // EX/MEM
   logic             exMemValid;
   logic [`XLEN-1:0] exMemAlu, exMemRs2, exMemPc4, memFwdValue;
   logic [4:0]       exMemRd;
   wbSel_t           exMemWbSel;
   logic             exMemRegWrite, exMemMemRead, exMemMemWrite, exMemIsHalt;
   // MEM/WB
   logic             memWbValid;
   logic [`XLEN-1:0] memWbAlu, memWbLoad, memWbPc4, wbValue;
   logic [4:0]       memWbRd;
   wbSel_t           memWbWbSel;
   logic             memWbRegWrite, memWbIsHalt;
   logic             haltQ;

   // instruction port, pc low bits are the byte address
   assign I_MEM_CSN  = RSTn | HALT;
   assign I_MEM_ADDR = pc[`IADDR_W-1:0];

   rvDecoder u_rvDecoder (
      .instr(ifIdInstr), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
      .aluOp(decAluOp), .brCond(decBrCond), .wbSel(decWbSel),
      .aluSrcImm(decAluSrcImm), .aluSrcPc(decAluSrcPc), .regWrite(decRegWrite),
      .memRead(decMemRead), .memWrite(decMemWrite), .isJump(decIsJump),
      .isJalr(decIsJalr), .isHalt(decIsHalt)
   );

   // register file read in ID, write-through covers the WB case
   assign RF_RA1 = decRs1;
   assign RF_RA2 = decRs2;

   rvHazardUnit u_rvHazardUnit (
      .exRs1(idExRs1), .exRs2(idExRs2), .idRs1(decRs1), .idRs2(decRs2),
      .exMemRead(idExValid & idExMemRead), .exRd(idExRd), .memRd(exMemRd),
      .wbRd(memWbRd), .memRegWrite(exMemValid & exMemRegWrite),
      .wbRegWrite(memWbValid & memWbRegWrite), .redirect(redirect),
      .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
   );

   // jal result in MEM is its return address, not the alu target
   assign memFwdValue = (exMemWbSel == wbPc4) ? exMemPc4 : exMemAlu;

   always_comb begin
      case (fwdA)
         fwdMem:  fwdRs1 = memFwdValue;
         fwdWb:   fwdRs1 = wbValue;
         default: fwdRs1 = idExRd1;
      endcase
      case (fwdB)
         fwdMem:  fwdRs2 = memFwdValue;
         fwdWb:   fwdRs2 = wbValue;
         default: fwdRs2 = idExRd2;
      endcase
   end

   assign aluA = idExAluSrcPc ? idExPc : fwdRs1;
   assign aluB = idExAluSrcImm ? idExImm : fwdRs2;

   rvAlu u_rvAlu (
      .opA(aluA), .opB(aluB), .aluOp(idExAluOp), .cmpA(fwdRs1), .cmpB(fwdRs2),
      .brCond(idExBrCond), .result(aluResult), .brTaken(brTaken)
   );

   assign exPc4    = idExPc + 32'd4;
   // jalr target drops bit 0
   assign exTarget = {aluResult[`XLEN-1:1], aluResult[0] & ~idExIsJalr};
   assign redirect = idExValid & (idExIsJump | brTaken);

   // control state: pc, valid bits, halt latch and retire counter
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc         <= `RESET_PC;
         ifIdValid  <= 1'b0;
         idExValid  <= 1'b0;
         exMemValid <= 1'b0;
         memWbValid <= 1'b0;
         haltQ      <= 1'b0;
         NUM_INST   <= '0;
      end else begin
         if (redirect) begin
            pc <= exTarget;
         end else if (!stall) begin
            pc <= pc + 32'd4;
         end
         if (flush) begin
            ifIdValid <= 1'b0;
         end else if (!stall) begin
            ifIdValid <= 1'b1;
         end
         // stall leaves a bubble in EX
         idExValid  <= ifIdValid & ~flush & ~stall;
         exMemValid <= idExValid;
         memWbValid <= exMemValid;
         if (memWbValid && memWbIsHalt) begin
            haltQ <= 1'b1;
         end
         // ebreak itself counts, anything behind it does not
         if (memWbValid && !haltQ) begin
            NUM_INST <= NUM_INST + 1'b1;
         end
      end
   end

   // pipeline payload
   always_ff @(posedge CLK) begin
      if (!stall) begin
         ifIdInstr <= I_MEM_DI;
         ifIdPc    <= pc;
      end
      idExPc        <= ifIdPc;
      idExRd1       <= RF_RD1;
      idExRd2       <= RF_RD2;
      idExImm       <= decImm;
      idExRs1       <= decRs1;
      idExRs2       <= decRs2;
      idExRd        <= decRd;
      idExAluOp     <= decAluOp;
      idExBrCond    <= decBrCond;
      idExWbSel     <= decWbSel;
      idExAluSrcImm <= decAluSrcImm;
      idExAluSrcPc  <= decAluSrcPc;
      idExRegWrite  <= decRegWrite;
      idExMemRead   <= decMemRead;
      idExMemWrite  <= decMemWrite;
      idExIsJump    <= decIsJump;
      idExIsJalr    <= decIsJalr;
      idExIsHalt    <= decIsHalt;
      exMemAlu      <= aluResult;
      exMemRs2      <= fwdRs2;
      exMemPc4      <= exPc4;
      exMemRd       <= idExRd;
      exMemWbSel    <= idExWbSel;
      exMemRegWrite <= idExRegWrite;
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemIsHalt   <= idExIsHalt;
      memWbAlu      <= exMemAlu;
      memWbLoad     <= D_MEM_DI;
      memWbPc4      <= exMemPc4;
      memWbRd       <= exMemRd;
      memWbWbSel    <= exMemWbSel;
      memWbRegWrite <= exMemRegWrite;
      memWbIsHalt   <= exMemIsHalt;
   end

   // data port, word address from the alu result
   assign D_MEM_CSN  = RSTn | HALT | ~(exMemValid & (exMemMemRead | exMemMemWrite));
   assign D_MEM_WEN  = ~(exMemValid & exMemMemWrite & ~HALT);
   assign D_MEM_ADDR = exMemAlu[`DADDR_W+1:2];
   assign D_MEM_DOUT = exMemRs2;

   always_comb begin
      case (memWbWbSel)
         wbMem:   wbValue = memWbLoad;
         wbPc4:   wbValue = memWbPc4;
         default: wbValue = memWbAlu;
      endcase
   end

   // halt is visible in the same cycle ebreak sits in WB
   assign HALT        = haltQ | (memWbValid & memWbIsHalt);
   assign RF_WE       = memWbValid & memWbRegWrite & ~HALT;
   assign RF_WA1      = memWbRd;
   assign RF_WD       = wbValue;
   assign OUTPUT_PORT = wbValue;

endmodule

`default_nettype wire

// ==== rvHazardUnit.sv ====
`default_nettype none

module rvHazardUnit (
   input  logic [4:0]      exRs1,
   input  logic [4:0]      exRs2,
   input  logic [4:0]      idRs1,
   input  logic [4:0]      idRs2,
   input  logic            exMemRead,
   input  logic [4:0]      exRd,
   input  logic [4:0]      memRd,
   input  logic [4:0]      wbRd,
   input  logic            memRegWrite,
   input  logic            wbRegWrite,
   input  logic            redirect,
   output rvPkg::fwdSel_t  fwdA,
   output rvPkg::fwdSel_t  fwdB,
   output logic            stall,
   output logic            flush
);
   import rvPkg::*;

   logic loadUse;

   // youngest producer wins, mem before wb, x0 never forwards
   function automatic fwdSel_t pickFwd(input logic [4:0] src);
      fwdSel_t sel;
      sel = fwdNone;
      if (memRegWrite && memRd != 5'd0 && memRd == src) begin
         sel = fwdMem;
      end else if (wbRegWrite && wbRd != 5'd0 && wbRd == src) begin
         sel = fwdWb;
      end
      return sel;
   endfunction

   assign fwdA = pickFwd(exRs1);
   assign fwdB = pickFwd(exRs2);

   // load in EX feeding the instruction in ID, data not ready until WB
   assign loadUse = exMemRead && exRd != 5'd0 && (exRd == idRs1 || exRd == idRs2);

   // a redirect kills the ID instruction anyway so it overrides the stall
   assign flush = redirect;
   assign stall = loadUse & ~redirect;

endmodule

`default_nettype wire

// ==== rvAlu.sv ====
`default_nettype none
`include "rvCore_consts.svh"

module rvAlu (
   input  logic [`XLEN-1:0] opA,
   input  logic [`XLEN-1:0] opB,
   input  rvPkg::aluOp_t    aluOp,
   input  logic [`XLEN-1:0] cmpA,
   input  logic [`XLEN-1:0] cmpB,
   input  rvPkg::brCond_t   brCond,
   output logic [`XLEN-1:0] result,
   output logic             brTaken
);
   import rvPkg::*;

   logic sltAB;
   logic ltCmp;

   assign sltAB = $signed(opA) < $signed(opB);
   // branch compare is signed, blt and bge only
   assign ltCmp = $signed(cmpA) < $signed(cmpB);

   always_comb begin
      case (aluOp)
         aluAdd:   result = opA + opB;
         aluSub:   result = opA - opB;
         aluAnd:   result = opA & opB;
         aluOr:    result = opA | opB;
         aluXor:   result = opA ^ opB;
         aluSlt:   result = {{(`XLEN-1){1'b0}}, sltAB};
         aluPassB: result = opB;
         default:  result = '0;
      endcase
   end

   always_comb begin
      case (brCond)
         brEq:    brTaken = (cmpA == cmpB);
         brNe:    brTaken = (cmpA != cmpB);
         brLt:    brTaken = ltCmp;
         brGe:    brTaken = ~ltCmp;
         default: brTaken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rvDecoder.sv ====
`default_nettype none
`include "rvCore_consts.svh"

module rvDecoder (
   input  logic [`XLEN-1:0] instr,
   output logic [4:0]       rs1,
   output logic [4:0]       rs2,
   output logic [4:0]       rd,
   output logic [`XLEN-1:0] imm,
   output rvPkg::aluOp_t    aluOp,
   output rvPkg::brCond_t   brCond,
   output rvPkg::wbSel_t    wbSel,
   output logic             aluSrcImm,
   output logic             aluSrcPc,
   output logic             regWrite,
   output logic             memRead,
   output logic             memWrite,
   output logic             isJump,
   output logic             isJalr,
   output logic             isHalt
);
   import rvPkg::*;

   opcode_t    opc;
   logic [2:0] funct3;
   logic       useRs1;
   logic       useRs2;

   assign opc    = opcode_t'(instr[6:0]);
   assign funct3 = instr[14:12];

   // unused source fields read as x0 so they never match in the hazard unit
   assign rs1 = useRs1 ? instr[19:15] : 5'd0;
   assign rs2 = useRs2 ? instr[24:20] : 5'd0;
   assign rd  = instr[11:7];

   always_comb begin
      // unknown opcode falls out as a no-op
      imm       = '0;
      aluOp     = aluAdd;
      brCond    = brNone;
      wbSel     = wbAlu;
      aluSrcImm = 1'b0;
      aluSrcPc  = 1'b0;
      regWrite  = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      isJump    = 1'b0;
      isJalr    = 1'b0;
      isHalt    = 1'b0;
      useRs1    = 1'b0;
      useRs2    = 1'b0;
      case (opc)
         opcOp, opcOpImm: begin
            useRs1    = 1'b1;
            useRs2    = (opc == opcOp);
            aluSrcImm = (opc == opcOpImm);
            imm       = {{20{instr[31]}}, instr[31:20]};
            regWrite  = 1'b1;
            case (funct3)
               // funct7 bit 5 selects sub, register form only
               3'b000: aluOp = (opc == opcOp && instr[30]) ? aluSub : aluAdd;
               3'b010: aluOp = aluSlt;
               3'b100: aluOp = aluXor;
               3'b110: aluOp = aluOr;
               3'b111: aluOp = aluAnd;
               // shifts and sltu are not supported
               default: regWrite = 1'b0;
            endcase
         end
         opcLui: begin
            imm       = {instr[31:12], 12'd0};
            aluOp     = aluPassB;
            aluSrcImm = 1'b1;
            regWrite  = 1'b1;
         end
         opcLoad: begin
            useRs1    = 1'b1;
            imm       = {{20{instr[31]}}, instr[31:20]};
            aluSrcImm = 1'b1;
            memRead   = 1'b1;
            regWrite  = 1'b1;
            wbSel     = wbMem;
         end
         opcStore: begin
            useRs1    = 1'b1;
            useRs2    = 1'b1;
            imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            aluSrcImm = 1'b1;
            memWrite  = 1'b1;
         end
         opcBranch: begin
            useRs1    = 1'b1;
            useRs2    = 1'b1;
            // adder forms pc + imm, compare runs on the side
            imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            aluSrcPc  = 1'b1;
            aluSrcImm = 1'b1;
            case (funct3)
               3'b000:  brCond = brEq;
               3'b001:  brCond = brNe;
               3'b100:  brCond = brLt;
               3'b101:  brCond = brGe;
               default: brCond = brNone;
            endcase
         end
         opcJal: begin
            imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            aluSrcPc  = 1'b1;
            aluSrcImm = 1'b1;
            isJump    = 1'b1;
            regWrite  = 1'b1;
            wbSel     = wbPc4;
         end
         opcJalr: begin
            useRs1    = 1'b1;
            imm       = {{20{instr[31]}}, instr[31:20]};
            aluSrcImm = 1'b1;
            isJump    = 1'b1;
            isJalr    = 1'b1;
            regWrite  = 1'b1;
            wbSel     = wbPc4;
         end
         opcSystem: begin
            // only ebreak does anything, ecall and csr ops are no-ops
            isHalt = (instr[31:20] == 12'h001) && (funct3 == 3'b000);
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rvPkg.sv ====
`default_nettype none
`include "rvCore_consts.svh"

package rvPkg;

   // major opcode classes seen by the decoder
   typedef enum logic [6:0] {
      opcOp     = `OPC_OP,
      opcOpImm  = `OPC_OP_IMM,
      opcLoad   = `OPC_LOAD,
      opcStore  = `OPC_STORE,
      opcBranch = `OPC_BRANCH,
      opcJal    = `OPC_JAL,
      opcJalr   = `OPC_JALR,
      opcLui    = `OPC_LUI,
      opcSystem = `OPC_SYSTEM
   } opcode_t;

   // passB carries the U immediate for lui
   typedef enum logic [2:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
   } aluOp_t;

   typedef enum logic [2:0] {brNone, brEq, brNe, brLt, brGe} brCond_t;

   // register file write data source
   typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSel_t;

   // operand source in EX
   typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel_t;

endpackage

`default_nettype wire

// ==== rvCore_consts.svh ====
`ifndef RVCORE_CONSTS_SVH
`define RVCORE_CONSTS_SVH

// datapath width
`define XLEN 32
// instruction byte address, data word address
`define IADDR_W 12
`define DADDR_W 12
// first fetch after reset
`define RESET_PC 32'h0000_0000

// rv32i major opcodes, instr[6:0]
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_LUI    7'b0110111
`define OPC_SYSTEM 7'b1110011

`endif
